// ==== include/rst_settings.svh ====
// Timing constants for the reset controller; widths must hold the counts they size
`ifndef RST_SETTINGS_SVH
`define RST_SETTINGS_SVH

// ============================================================
// Watchdog
// ============================================================

// Idle cycles without a kick before a watchdog reset request
// Picked above 255 so the count crosses the 8-bit carry
`define RST_WDT_TIMEOUT 16'd300

// ============================================================
// Power pin filter
// ============================================================

// Consecutive synchronized low samples needed to accept the pin
`define RST_PWR_FILTER 3'd4
`define RST_PWR_FILTER_W 3

// ============================================================
// Reset stretching
// ============================================================

// Cycles system_reset stays high after the last request is gone
`define RST_STRETCH 4'd8
`define RST_STRETCH_W 4

`endif

// ==== design/rst_pkg.sv ====
// Shared reset controller types; cause code 3 is unused and never produced
package rst_pkg;

    // ============================================================
    // Reset cause
    // ============================================================

    // Lower code means higher priority when sources overlap
    typedef enum logic [1:0] {
        CAUSE_POWER    = 2'd0,
        CAUSE_EXTERNAL = 2'd1,
        CAUSE_WATCHDOG = 2'd2
    } reset_cause_e;

    // ============================================================
    // Sequencer state
    // ============================================================

    // SEQ_ASSERT is the state left behind by the external reset
    typedef enum logic [1:0] {
        SEQ_ASSERT,
        SEQ_STRETCH,
        SEQ_IDLE
    } seq_state_e;

endpackage

// ==== design/reset_req_if.sv ====
// Reset request bundle between filter, watchdog and sequencer; all signals are plain levels
interface reset_req_if;

    // Filtered power pin request, high while the pin is held low
    logic        pwr_req;

    // Watchdog timeout request, high while count is past the limit
    logic        wdt_req;

    // Keeps the watchdog cleared while a reset is in progress
    logic        wdt_hold;

    // Current watchdog count, shown at the top level
    logic [15:0] wdt_count;

    modport filter (
        output pwr_req
    );

    modport watchdog (
        output wdt_req,
        output wdt_count,
        input  wdt_hold
    );

    modport sequencer (
        input  pwr_req,
        input  wdt_req,
        input  wdt_count,
        output wdt_hold
    );

endinterface

// ==== design/prefix_adder16.sv ====
// Fixed 16-bit combinational adder; no pipelining, carry path is four prefix levels deep
module prefix_adder16 (
    input  logic [15:0] a,
    input  logic [15:0] b,
    input  logic        cin,
    output logic [15:0] sum,
    output logic        cout
);

    // ============================================================
    // Bit level generate and propagate
    // ============================================================

    logic [15:0] p;
    logic [15:0] g;

    // Group terms per level, level 0 is the bit level
    // gl[k][i] covers bits down to max(0, i - 2^k + 1), plus cin
    logic [4:0][15:0] gl;
    // Group propagate only needed up to the last merging level
    logic [3:0][15:0] pl;

    assign p = a ^ b;
    assign g = a & b;

    // Carry in treated as a generate entering bit 0
    assign gl[0] = {g[15:1], g[0] | (p[0] & cin)};
    assign pl[0] = p;

    // ============================================================
    // Prefix network, spans 1, 2, 4, 8
    // ============================================================

    for (genvar s = 0; s < 4; s++) begin : g_level
        for (genvar i = 0; i < 16; i++) begin : g_bit
            if (i >= (1 << s)) begin : g_merge
                // Black cell
                assign gl[s+1][i] = gl[s][i] | (pl[s][i] & gl[s][i - (1 << s)]);
                if (s < 3) begin : g_prop
                    assign pl[s+1][i] = pl[s][i] & pl[s][i - (1 << s)];
                end
            end else begin : g_pass
                // Already complete down to bit 0, just buffered
                assign gl[s+1][i] = gl[s][i];
                if (s < 3) begin : g_prop
                    assign pl[s+1][i] = pl[s][i];
                end
            end
        end
    end

    // ============================================================
    // Sum and carry out
    // ============================================================

    // Carry into bit i is the full group generate of bits i-1..0
    assign sum  = p ^ {gl[4][14:0], cin};
    assign cout = gl[4][15];

endmodule

// ==== design/watchdog_timer.sv ====
// Single clock watchdog; count saturates at all ones, kick and hold win over counting
`include "rst_settings.svh"

module watchdog_timer (
    input logic              clk,
    input logic              ext_reset_active,
    input logic              enable,
    input logic              watchdog_kick,
    reset_req_if.watchdog    req
);

    logic [15:0] count;
    logic [15:0] count_inc;
    logic        count_wrap;

    // Prefix adder used as incrementer, carry in supplies the +1
    prefix_adder16 u_adder (
        .a    (count),
        .b    (16'd0),
        .cin  (1'b1),
        .sum  (count_inc),
        .cout (count_wrap)
    );

    // ============================================================
    // Counter
    // ============================================================

    always_ff @(posedge clk) begin
        if (ext_reset_active) begin
            count <= '0;
        end else if (!enable || watchdog_kick || req.wdt_hold) begin
            count <= '0;
        end else if (!count_wrap) begin
            count <= count_inc;
        end
    end

    assign req.wdt_count = count;

    // Level request, drops once the sequencer holds the count at zero
    assign req.wdt_req = (count >= `RST_WDT_TIMEOUT);

    // ============================================================
    // Checks
    // ============================================================

    // A kick always restarts the count on the following edge
    a_kick_clears : assert property (
        @(posedge clk) disable iff (ext_reset_active)
        watchdog_kick |=> (req.wdt_count == 16'd0)
    ) else $error("watchdog count not cleared after kick");

endmodule

// ==== design/reset_input_filter.sv ====
// Active-low power pin, async to clk; pulses under the filter length are ignored
`include "rst_settings.svh"

module reset_input_filter (
    input logic          clk,
    input logic          ext_reset_active,
    input logic          pwr_reset_n,
    reset_req_if.filter  req
);

    logic                         pin_meta;
    logic                         pin_sync;
    logic [`RST_PWR_FILTER_W-1:0] low_count;

    // ============================================================
    // Two flop synchronizer
    // ============================================================

    // Idles high so a fresh reset does not look like a power event
    always_ff @(posedge clk) begin
        if (ext_reset_active) begin
            pin_meta <= 1'b1;
            pin_sync <= 1'b1;
        end else begin
            pin_meta <= pwr_reset_n;
            pin_sync <= pin_meta;
        end
    end

    // ============================================================
    // Glitch filter
    // ============================================================

    // Saturating count of consecutive low samples
    always_ff @(posedge clk) begin
        if (ext_reset_active) begin
            low_count <= '0;
        end else if (pin_sync) begin
            low_count <= '0;
        end else if (low_count != `RST_PWR_FILTER) begin
            low_count <= low_count + 1'b1;
        end
    end

    assign req.pwr_req = (low_count == `RST_PWR_FILTER);

    // A request can only start while the synchronized pin is low
    a_no_rise_when_high : assert property (
        @(posedge clk) disable iff (ext_reset_active)
        $rose(req.pwr_req) |-> !pin_sync
    ) else $error("power request rose with pin high");

endmodule

// ==== design/reset_sequencer.sv ====
// Cause is sticky and never reads as "none"; external reset doubles as this block's own reset
`include "rst_settings.svh"

module reset_sequencer (
    input  logic                  clk,
    input  logic                  ext_reset_active,
    reset_req_if.sequencer        req,
    output logic                  system_reset,
    output rst_pkg::reset_cause_e reset_source,
    output logic [15:0]           watchdog_count
);

    rst_pkg::seq_state_e        state;
    rst_pkg::seq_state_e        state_nx;
    rst_pkg::reset_cause_e      req_cause;
    logic                       any_req;
    logic [`RST_STRETCH_W-1:0]  stretch_cnt;

    // ============================================================
    // Request priority
    // ============================================================

    // External reset is taken by the reset branch of the state register
    assign any_req = req.pwr_req | req.wdt_req;

    always_comb begin
        if (req.pwr_req) begin
            req_cause = rst_pkg::CAUSE_POWER;
        end else begin
            req_cause = rst_pkg::CAUSE_WATCHDOG;
        end
    end

    // ============================================================
    // State machine
    // ============================================================

    always_comb begin
        state_nx = state;
        case (state)
            rst_pkg::SEQ_IDLE: begin
                if (any_req) begin
                    state_nx = rst_pkg::SEQ_ASSERT;
                end
            end
            rst_pkg::SEQ_ASSERT: begin
                if (!any_req) begin
                    state_nx = rst_pkg::SEQ_STRETCH;
                end
            end
            rst_pkg::SEQ_STRETCH: begin
                if (any_req) begin
                    state_nx = rst_pkg::SEQ_ASSERT;
                end else if (stretch_cnt == `RST_STRETCH - 1'b1) begin
                    state_nx = rst_pkg::SEQ_IDLE;
                end
            end
            default: state_nx = rst_pkg::SEQ_ASSERT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ext_reset_active) begin
            state        <= rst_pkg::SEQ_ASSERT;
            system_reset <= 1'b1;
            reset_source <= rst_pkg::CAUSE_EXTERNAL;
            stretch_cnt  <= '0;
        end else begin
            state        <= state_nx;
            system_reset <= (state_nx != rst_pkg::SEQ_IDLE);

            // Fresh latch from idle, otherwise only a stronger source overrides
            if (any_req && (state == rst_pkg::SEQ_IDLE || req_cause < reset_source)) begin
                reset_source <= req_cause;
            end

            if (state == rst_pkg::SEQ_STRETCH && !any_req) begin
                stretch_cnt <= stretch_cnt + 1'b1;
            end else begin
                stretch_cnt <= '0;
            end
        end
    end

    assign req.wdt_hold   = (state != rst_pkg::SEQ_IDLE);
    assign watchdog_count = req.wdt_count;

    // ============================================================
    // Checks
    // ============================================================

    a_req_gives_reset : assert property (
        @(posedge clk) disable iff (ext_reset_active)
        (req.pwr_req || req.wdt_req) |=> system_reset
    ) else $error("request not followed by system_reset");

    a_no_idle_with_req : assert property (
        @(posedge clk) disable iff (ext_reset_active)
        (state == rst_pkg::SEQ_STRETCH && (req.pwr_req || req.wdt_req))
            |=> (state != rst_pkg::SEQ_IDLE)
    ) else $error("stretch ended while a request was present");

endmodule

// ==== design/reset_ctrl_top.sv ====
// One clock domain only; power pin is the sole async input, reset_source holds cause codes 0-2
module reset_ctrl_top (
    input  logic        clk,
    input  logic        ext_reset_active,
    input  logic        enable,
    input  logic        watchdog_kick,
    input  logic        pwr_reset_n,
    output logic        system_reset,
    output logic [1:0]  reset_source,
    output logic [15:0] watchdog_count
);

    // Request bundle shared by the three blocks
    reset_req_if req_bus ();

    // ============================================================
    // Reset sources
    // ============================================================

    reset_input_filter u_filter (
        .clk              (clk),
        .ext_reset_active (ext_reset_active),
        .pwr_reset_n      (pwr_reset_n),
        .req              (req_bus.filter)
    );

    watchdog_timer u_watchdog (
        .clk              (clk),
        .ext_reset_active (ext_reset_active),
        .enable           (enable),
        .watchdog_kick    (watchdog_kick),
        .req              (req_bus.watchdog)
    );

    // ============================================================
    // Sequencer
    // ============================================================

    // Cause enum leaves through the plain 2-bit port
    reset_sequencer u_sequencer (
        .clk              (clk),
        .ext_reset_active (ext_reset_active),
        .req              (req_bus.sequencer),
        .system_reset     (system_reset),
        .reset_source     (reset_source),
        .watchdog_count   (watchdog_count)
    );

endmodule

// ==== bench/reset_ctrl_tb.sv ====
// Expects the default timing constants; assumes sync plus filter delay is shorter than the stretch
`include "rst_settings.svh"

module reset_ctrl_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WDT_TIMEOUT = int'(`RST_WDT_TIMEOUT);
    localparam int PWR_FILTER  = int'(`RST_PWR_FILTER);
    localparam int STRETCH     = int'(`RST_STRETCH);
    // Longest delay from a source release to system_reset low, with margin
    localparam int TAIL        = PWR_FILTER + STRETCH + 12;

    typedef enum {
        ACT_EXT_PULSE, ACT_PWR_LOW, ACT_IDLE, ACT_KICKED, ACT_DISABLED, ACT_WDT_PWR
    } action_e;

    logic        clk;
    logic        ext_reset_active;
    logic        enable;
    logic        watchdog_kick;
    logic        pwr_reset_n;
    logic        system_reset;
    logic [1:0]  reset_source;
    logic [15:0] watchdog_count;

    // Stimulus table, one entry per test
    string                 row_name[$];
    action_e               row_act[$];
    int                    row_dur[$];
    bit                    row_rst[$];
    rst_pkg::reset_cause_e row_cause[$];

    int   n_checks    = 0;
    int   n_errors    = 0;
    int   rises       = 0;
    int   falls       = 0;
    int   cycle_count = 0;
    int   cycle_limit = 0;
    logic last_level  = 1'b1;

    reset_ctrl_top DUT (
        .clk              (clk),
        .ext_reset_active (ext_reset_active),
        .enable           (enable),
        .watchdog_kick    (watchdog_kick),
        .pwr_reset_n      (pwr_reset_n),
        .system_reset     (system_reset),
        .reset_source     (reset_source),
        .watchdog_count   (watchdog_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ============================================================
    // Compare tasks
    // ============================================================

    task automatic check_level(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Error: %s system_reset expected %0b actual %0b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Error: %s watchdog_count expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_cause(input string name, input rst_pkg::reset_cause_e exp,
                               input rst_pkg::reset_cause_e act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Error: %s reset_source expected %s (%0d) actual %s (%0d)",
                     name, exp.name(), exp, act.name(), act);
        end
    endtask

    task automatic report_failure(input string msg);
        n_errors++;
        $display("%s", msg);
    endtask

    function automatic rst_pkg::reset_cause_e cause_now();
        return rst_pkg::reset_cause_e'(reset_source);
    endfunction

    // ============================================================
    // Cycle helpers
    // ============================================================

    // Outputs are read at the falling edge, counting system_reset pulses
    task automatic settle_sample();
        @(negedge clk);
        if (system_reset === 1'b1 && last_level === 1'b0) rises++;
        if (system_reset === 1'b0 && last_level === 1'b1) falls++;
        last_level = system_reset;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        settle_sample();
    endtask

    task automatic kick_pulse();
        @(posedge clk);
        watchdog_kick <= 1'b1;
        settle_sample();
        @(posedge clk);
        watchdog_kick <= 1'b0;
        settle_sample();
    endtask

    task automatic wait_level(input string name, input logic level, input int max_cycles,
                              output int waited);
        waited = 0;
        while (system_reset !== level && waited < max_cycles) begin
            idle_cycle();
            waited++;
        end
        if (system_reset !== level)
            report_failure($sformatf("%s: system_reset did not go to %0b within %0d cycles",
                                     name, level, max_cycles));
    endtask

    task automatic hold_pin_low(input int cycles);
        @(posedge clk);
        pwr_reset_n <= 1'b0;
        settle_sample();
        repeat (cycles - 1) idle_cycle();
        @(posedge clk);
        pwr_reset_n <= 1'b1;
        settle_sample();
    endtask

    // ============================================================
    // Test actions
    // ============================================================

    task automatic run_kicked(input string name, input int cycles);
        int gap;
        gap = 0;
        repeat (cycles) begin
            @(posedge clk);
            if (gap == 0) begin
                watchdog_kick <= 1'b1;
                gap = int'($urandom_range(WDT_TIMEOUT - 10, 1));
            end else begin
                watchdog_kick <= 1'b0;
                gap--;
            end
            settle_sample();
            check_level(name, 1'b0, system_reset);
        end
        @(posedge clk);
        watchdog_kick <= 1'b0;
        settle_sample();
    endtask

    // Count climbs by one per cycle from the kick until the timeout reset
    task automatic run_idle(input string name);
        int          exp_count;
        logic [15:0] prev_count;
        bit          crossed;
        exp_count  = 0;
        prev_count = watchdog_count;
        crossed    = 1'b0;
        check_count({name, "_start"}, 16'd0, watchdog_count);
        while (system_reset !== 1'b1 && exp_count < WDT_TIMEOUT + 20) begin
            prev_count = watchdog_count;
            idle_cycle();
            exp_count++;
            if (system_reset !== 1'b1) begin
                check_count(name, 16'(exp_count), watchdog_count);
                if (prev_count == 16'd255 && watchdog_count == 16'd256) crossed = 1'b1;
            end
        end
        if (system_reset !== 1'b1) begin
            report_failure($sformatf("%s: no watchdog reset after %0d idle cycles",
                                     name, exp_count));
        end else begin
            // Sequencer reacts one edge after the count reaches the limit
            check_count({name, "_limit"}, 16'(WDT_TIMEOUT), prev_count);
            idle_cycle();
            check_count({name, "_hold"}, 16'd0, watchdog_count);
        end
        if (!crossed)
            report_failure($sformatf("%s: count never stepped from 255 to 256", name));
    endtask

    task automatic run_row(input int r);
        string name;
        int    waited;
        name  = row_name[r];
        rises = 0;
        falls = 0;
        kick_pulse();
        case (row_act[r])
            ACT_KICKED:  run_kicked(name, row_dur[r]);
            ACT_IDLE:    run_idle(name);
            ACT_PWR_LOW: hold_pin_low(row_dur[r]);
            ACT_DISABLED: begin
                @(posedge clk);
                enable <= 1'b0;
                settle_sample();
                repeat (row_dur[r]) begin
                    idle_cycle();
                    check_count(name, 16'd0, watchdog_count);
                    check_level(name, 1'b0, system_reset);
                end
                @(posedge clk);
                enable <= 1'b1;
                settle_sample();
            end
            ACT_EXT_PULSE: begin
                @(posedge clk);
                ext_reset_active <= 1'b1;
                settle_sample();
                repeat (row_dur[r] - 1) idle_cycle();
                @(posedge clk);
                ext_reset_active <= 1'b0;
                settle_sample();
            end
            ACT_WDT_PWR: begin
                wait_level(name, 1'b1, WDT_TIMEOUT + 20, waited);
                check_cause({name, "_first"}, rst_pkg::CAUSE_WATCHDOG, cause_now());
                // Pin falls as the sequencer enters the stretch
                idle_cycle();
                hold_pin_low(row_dur[r]);
                check_level({name, "_release"}, 1'b1, system_reset);
            end
            default: ;
        endcase

        if (row_rst[r]) begin
            wait_level(name, 1'b0, TAIL, waited);
            if (row_act[r] == ACT_WDT_PWR && waited < STRETCH)
                report_failure($sformatf("%s: reset ended %0d cycles after pin release",
                                         name, waited));
            if (rises != 1 || falls != 1)
                report_failure($sformatf("%s: expected one reset pulse, saw %0d rises %0d falls",
                                         name, rises, falls));
        end else begin
            repeat (TAIL) idle_cycle();
            if (rises != 0)
                report_failure($sformatf("%s: unexpected system_reset pulse", name));
        end
        check_level({name, "_end"}, 1'b0, system_reset);
        check_cause(name, row_cause[r], cause_now());
    endtask

    task automatic add_row(input string name, input action_e act, input int dur,
                           input bit rst, input rst_pkg::reset_cause_e cause);
        row_name.push_back(name);
        row_act.push_back(act);
        row_dur.push_back(dur);
        row_rst.push_back(rst);
        row_cause.push_back(cause);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        int waited;
        int limit;
        ext_reset_active = 1'b1;
        enable           = 1'b1;
        watchdog_kick    = 1'b0;
        pwr_reset_n      = 1'b1;
        void'($urandom(9));

        // Cause is sticky, so rows without a reset expect the previous one
        add_row("kicked_run", ACT_KICKED, 2000, 1'b0, rst_pkg::CAUSE_EXTERNAL);
        add_row("wdt_timeout", ACT_IDLE, WDT_TIMEOUT, 1'b1, rst_pkg::CAUSE_WATCHDOG);
        add_row("disabled_run", ACT_DISABLED, WDT_TIMEOUT + 100, 1'b0, rst_pkg::CAUSE_WATCHDOG);
        add_row("pwr_glitch", ACT_PWR_LOW, PWR_FILTER - 1, 1'b0, rst_pkg::CAUSE_WATCHDOG);
        add_row("pwr_long", ACT_PWR_LOW, 20, 1'b1, rst_pkg::CAUSE_POWER);
        add_row("wdt_then_pwr", ACT_WDT_PWR, 12, 1'b1, rst_pkg::CAUSE_POWER);
        add_row("ext_pulse", ACT_EXT_PULSE, 3, 1'b1, rst_pkg::CAUSE_EXTERNAL);
        add_row("kicked_after", ACT_KICKED, 800, 1'b0, rst_pkg::CAUSE_EXTERNAL);

        limit = 40;
        foreach (row_dur[i]) limit += row_dur[i] + WDT_TIMEOUT + STRETCH + TAIL + 10;
        cycle_limit = limit + 200;

        repeat (4) @(posedge clk);
        ext_reset_active <= 1'b0;
        settle_sample();
        check_level("init_reset", 1'b1, system_reset);
        check_cause("init_reset", rst_pkg::CAUSE_EXTERNAL, cause_now());
        wait_level("init_reset", 1'b0, STRETCH + 6, waited);

        foreach (row_name[r]) run_row(r);

        $display("Checks: %0d  Errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Run limit from the table lengths
    initial begin
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Checks: %0d  Errors: %0d", n_checks, n_errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
design/rst_pkg.sv
design/reset_req_if.sv
design/prefix_adder16.sv
design/watchdog_timer.sv
design/reset_input_filter.sv
design/reset_sequencer.sv
design/reset_ctrl_top.sv
bench/reset_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the reset controller testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module reset_ctrl_tb \
    --Mdir obj_dir -o reset_ctrl_sim

sim_out=$(./obj_dir/reset_ctrl_sim)
echo "$sim_out"

if grep -qx "RESULT: PASS" <<< "$sim_out"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
